// ==== design/noc_route_pkg.sv ====
`default_nettype none

// routing view of the mesh: port count, coordinates and next-hop directions
package noc_route_pkg;

  // router ports: north, east, south, west and the local injection port
  localparam int unsigned NumInputs = 5;

  // index into the input ports, wide enough for the arbiter pointer
  localparam int unsigned InputIdxWidth = $clog2(NumInputs);

  // a 3 bit coordinate per axis, so meshes up to 8x8
  localparam int unsigned CoordWidth = 3;

  typedef logic [CoordWidth-1:0]    coord_t;
  typedef logic [InputIdxWidth-1:0] input_idx_t;

  // next-hop direction as computed by the look-ahead route unit
  // y grows towards north, x grows towards east
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_dir_e;

  // the output port this allocation stage serves
  localparam route_dir_e OutputDir = East;

endpackage

`default_nettype wire

// ==== design/noc_vc_pkg.sv ====
`default_nettype none

// virtual channels on the downstream input port and their credit counts
package noc_vc_pkg;

  // one vc per possible next-hop direction behind the link
  localparam int unsigned NumVc = 4;

  localparam int unsigned VcIdWidth = $clog2(NumVc);

  // buffer slots per vc on the downstream router
  localparam int unsigned VcDepth = 2;

  // must hold 0 up to VcDepth inclusive
  localparam int unsigned CreditWidth = $clog2(VcDepth + 1);

  typedef logic [VcIdWidth-1:0]   vc_id_t;
  typedef logic [CreditWidth-1:0] credit_t;

endpackage

`default_nettype wire

// ==== design/sa_global_arbiter.sv ====
`default_nettype none

// round-robin switch arbiter for one output port
// the pointer marks the input with highest priority
module sa_global_arbiter (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic [noc_route_pkg::NumInputs-1:0]  req_i,
  input  logic                                 update_i,
  output logic                                 sa_v_o,
  output logic [noc_route_pkg::NumInputs-1:0]  grant_oh_o
);
  import noc_route_pkg::*;

  localparam input_idx_t LastInput = input_idx_t'(NumInputs - 1);

  input_idx_t ptr_q;
  input_idx_t ptr_d;
  input_idx_t grant_idx;
  logic       found;

  assign sa_v_o = |req_i;

  // scan from the pointer upwards and wrap, first request wins
  always_comb begin
    int unsigned idx;
    grant_oh_o = '0;
    grant_idx  = '0;
    found      = 1'b0;
    for (int unsigned i = 0; i < NumInputs; i++) begin
      idx = (int'(ptr_q) + i) % NumInputs;
      if (!found && req_i[idx]) begin
        found           = 1'b1;
        grant_oh_o[idx] = 1'b1;
        grant_idx       = input_idx_t'(idx);
      end
    end
  end

  // winner drops to lowest priority
  assign ptr_d = (grant_idx == LastInput) ? '0 : grant_idx + 1'b1;

  // only a completed allocation moves the pointer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (update_i) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/look_ahead_route.sv ====
`default_nettype none

// xy routing decision taken one hop ahead, at the router behind OutputDir
module look_ahead_route (
  input  noc_route_pkg::coord_t     [noc_route_pkg::NumInputs-1:0] dest_x_i,
  input  noc_route_pkg::coord_t     [noc_route_pkg::NumInputs-1:0] dest_y_i,
  input  noc_route_pkg::coord_t                                    router_x_i,
  input  noc_route_pkg::coord_t                                    router_y_i,
  output noc_route_pkg::route_dir_e [noc_route_pkg::NumInputs-1:0] la_route_o
);
  import noc_route_pkg::*;

  coord_t next_x;
  coord_t next_y;

  // position of the neighbour reached through this output
  always_comb begin
    next_x = router_x_i;
    next_y = router_y_i;
    case (OutputDir)
      North:   next_y = router_y_i + 1'b1;
      East:    next_x = router_x_i + 1'b1;
      South:   next_y = router_y_i - 1'b1;
      West:    next_x = router_x_i - 1'b1;
      default: next_x = router_x_i;
    endcase
  end

  // x first, then y, eject once both match
  always_comb begin
    for (int unsigned i = 0; i < NumInputs; i++) begin
      if (dest_x_i[i] > next_x) begin
        la_route_o[i] = East;
      end else if (dest_x_i[i] < next_x) begin
        la_route_o[i] = West;
      end else if (dest_y_i[i] > next_y) begin
        la_route_o[i] = North;
      end else if (dest_y_i[i] < next_y) begin
        la_route_o[i] = South;
      end else begin
        la_route_o[i] = Eject;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/vc_credit_tracker.sv ====
`default_nettype none

// free slot count for every vc of the downstream input buffer
module vc_credit_tracker (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             consume_v_i,
  input  noc_vc_pkg::vc_id_t               consume_id_i,
  input  logic                             credit_v_i,
  input  noc_vc_pkg::vc_id_t               credit_vc_id_i,
  output logic [noc_vc_pkg::NumVc-1:0]     vc_free_o
);
  import noc_vc_pkg::*;

  localparam credit_t MaxCredit = credit_t'(VcDepth);

  credit_t [NumVc-1:0] credit_q;
  credit_t [NumVc-1:0] credit_d;
  logic    [NumVc-1:0] inc;
  logic    [NumVc-1:0] dec;

  always_comb begin
    for (int unsigned v = 0; v < NumVc; v++) begin
      inc[v]      = credit_v_i  && (credit_vc_id_i == vc_id_t'(v));
      dec[v]      = consume_v_i && (consume_id_i == vc_id_t'(v));
      credit_d[v] = credit_q[v];
      // return and consume together on one vc cancel out
      if (inc[v] && !dec[v] && (credit_q[v] != MaxCredit)) begin
        credit_d[v] = credit_q[v] + 1'b1;
      end else if (dec[v] && !inc[v] && (credit_q[v] != '0)) begin
        credit_d[v] = credit_q[v] - 1'b1;
      end
    end
  end

  // downstream buffers start out empty
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned v = 0; v < NumVc; v++) begin
        credit_q[v] <= MaxCredit;
      end
    end else begin
      credit_q <= credit_d;
    end
  end

  always_comb begin
    for (int unsigned v = 0; v < NumVc; v++) begin
      vc_free_o[v] = (credit_q[v] != '0);
    end
  end

endmodule

`default_nettype wire

// ==== design/vc_selection.sv ====
`default_nettype none

// picks a vc for every preferred slot
// the matching vc if it has credit, else the lowest free one
module vc_selection (
  input  logic [noc_vc_pkg::NumVc-1:0]                        vc_free_i,
  output logic [noc_vc_pkg::NumVc-1:0]                        sel_v_o,
  output noc_vc_pkg::vc_id_t [noc_vc_pkg::NumVc-1:0]          sel_id_o
);
  import noc_vc_pkg::*;

  logic   any_free;
  vc_id_t lowest_free;

  assign any_free = |vc_free_i;

  // walk downwards so the lowest free index is left at the end
  always_comb begin
    lowest_free = '0;
    for (int v = NumVc - 1; v >= 0; v--) begin
      if (vc_free_i[v]) begin
        lowest_free = vc_id_t'(v);
      end
    end
  end

  always_comb begin
    for (int unsigned d = 0; d < NumVc; d++) begin
      sel_v_o[d] = any_free;
      if (vc_free_i[d]) begin
        sel_id_o[d] = vc_id_t'(d);
      end else begin
        // fallback, may still be refused by vc_assignment
        sel_id_o[d] = lowest_free;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/vc_assignment.sv ====
`default_nettype none

// binds the switch allocation winner to a downstream vc
// runs after the global arbiter in the same cycle
module vc_assignment (
  input  logic                                                    sa_global_v_i,
  input  logic [noc_route_pkg::NumInputs-1:0]                     sa_global_input_dir_oh_i,
  input  noc_route_pkg::route_dir_e [noc_route_pkg::NumInputs-1:0] look_ahead_routing_i,
  input  logic [noc_vc_pkg::NumVc-1:0]                            vc_selection_v_i,
  input  noc_vc_pkg::vc_id_t [noc_vc_pkg::NumVc-1:0]              vc_selection_id_i,
  input  logic                                                    require_correct_vc_i,
  output logic                                                    vc_assignment_v_o,
  output noc_vc_pkg::vc_id_t                                      vc_assignment_id_o,
  output noc_route_pkg::route_dir_e                               look_ahead_routing_sel_o
);
  import noc_route_pkg::*;
  import noc_vc_pkg::*;

  localparam int unsigned DirWidth = $bits(route_dir_e);

  // the input port this link lands on at the next router
  // N<->S and E<->W, so East output feeds the West input
  localparam int unsigned NextInputDir = (int'(OutputDir) + 2) % 4;

  logic [DirWidth-1:0] la_sel_bits;
  vc_id_t              pref_slot;
  logic                correct_vc;

  // one-hot and-or mux over the look-ahead directions
  // with no grant the result is zero, masked by sa_global_v_i below
  always_comb begin
    la_sel_bits = '0;
    for (int unsigned i = 0; i < NumInputs; i++) begin
      la_sel_bits = la_sel_bits
                  | ({DirWidth{sa_global_input_dir_oh_i[i]}} & look_ahead_routing_i[i]);
    end
  end

  assign look_ahead_routing_sel_o = route_dir_e'(la_sel_bits);

  // the next router has no vc towards the port the flit came in on,
  // so directions above that port shift down by one
  // for East this gives N->0, E->1, S->2, eject->3
  always_comb begin
    if (la_sel_bits > NextInputDir) begin
      pref_slot = vc_id_t'(la_sel_bits - 1'b1);
    end else begin
      pref_slot = vc_id_t'(la_sel_bits);
    end
  end

  assign vc_assignment_id_o = vc_selection_id_i[pref_slot];

  // strict mode refuses a fallback vc
  assign correct_vc = ~require_correct_vc_i | (vc_assignment_id_o == pref_slot);

  assign vc_assignment_v_o = sa_global_v_i
                           & vc_selection_v_i[pref_slot]
                           & correct_vc;

endmodule

`default_nettype wire

// ==== design/output_alloc_top.sv ====
`default_nettype none

// east output allocation: switch arbitration, look-ahead route, vc binding
// the result is registered, so it appears one cycle after the request
module output_alloc_top #(
  parameter noc_route_pkg::coord_t RouterX = noc_route_pkg::coord_t'(1),
  parameter noc_route_pkg::coord_t RouterY = noc_route_pkg::coord_t'(1)
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic [noc_route_pkg::NumInputs-1:0]                 req_v_i,
  input  noc_route_pkg::coord_t [noc_route_pkg::NumInputs-1:0] dest_x_i,
  input  noc_route_pkg::coord_t [noc_route_pkg::NumInputs-1:0] dest_y_i,
  input  logic                                                require_correct_vc_i,
  input  logic                                                credit_v_i,
  input  noc_vc_pkg::vc_id_t                                  credit_vc_id_i,
  output logic [noc_route_pkg::NumInputs-1:0]                 grant_oh_o,
  output logic                                                out_v_o,
  output noc_vc_pkg::vc_id_t                                  out_vc_id_o,
  output noc_route_pkg::route_dir_e                           out_la_route_o
);
  import noc_route_pkg::*;
  import noc_vc_pkg::*;

  logic                        sa_v;
  logic       [NumInputs-1:0]  sa_grant_oh;
  route_dir_e [NumInputs-1:0]  la_route;
  logic       [NumVc-1:0]      vc_free;
  logic       [NumVc-1:0]      sel_v;
  vc_id_t     [NumVc-1:0]      sel_id;
  logic                        assign_v;
  vc_id_t                      assign_id;
  route_dir_e                  la_route_sel;

  // pointer only advances when the winner actually got a vc
  sa_global_arbiter u_sa_global_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_v_i),
    .update_i   (assign_v),
    .sa_v_o     (sa_v),
    .grant_oh_o (sa_grant_oh)
  );

  look_ahead_route u_look_ahead_route (
    .dest_x_i   (dest_x_i),
    .dest_y_i   (dest_y_i),
    .router_x_i (RouterX),
    .router_y_i (RouterY),
    .la_route_o (la_route)
  );

  // consume lands on the same edge as out_v_o
  vc_credit_tracker u_vc_credit_tracker (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .consume_v_i    (assign_v),
    .consume_id_i   (assign_id),
    .credit_v_i     (credit_v_i),
    .credit_vc_id_i (credit_vc_id_i),
    .vc_free_o      (vc_free)
  );

  vc_selection u_vc_selection (
    .vc_free_i (vc_free),
    .sel_v_o   (sel_v),
    .sel_id_o  (sel_id)
  );

  vc_assignment u_vc_assignment (
    .sa_global_v_i            (sa_v),
    .sa_global_input_dir_oh_i (sa_grant_oh),
    .look_ahead_routing_i     (la_route),
    .vc_selection_v_i         (sel_v),
    .vc_selection_id_i        (sel_id),
    .require_correct_vc_i     (require_correct_vc_i),
    .vc_assignment_v_o        (assign_v),
    .vc_assignment_id_o       (assign_id),
    .look_ahead_routing_sel_o (la_route_sel)
  );

  // a failed allocation shows no grant at all
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_v_o    <= 1'b0;
      grant_oh_o <= '0;
    end else begin
      out_v_o    <= assign_v;
      grant_oh_o <= assign_v ? sa_grant_oh : '0;
    end
  end

  // vc id and direction only mean something while out_v_o is high
  always_ff @(posedge clk_i) begin
    out_vc_id_o    <= assign_id;
    out_la_route_o <= la_route_sel;
  end

endmodule

`default_nettype wire

// ==== sim/tb_output_alloc.sv ====
`default_nettype none

module tb_output_alloc;
  timeunit 1ns;
  timeprecision 1ps;

  import noc_route_pkg::*;
  import noc_vc_pkg::*;

  localparam int unsigned ResetWaitCycles = 20;
  localparam int unsigned MaxDataLines    = 200;
  localparam string       DataFile        = "sim/output_alloc_testdata.txt";

  logic                   clk;
  logic                   arst_n;
  logic   [NumInputs-1:0] req_v;
  coord_t [NumInputs-1:0] dest_x;
  coord_t [NumInputs-1:0] dest_y;
  logic                   require_correct_vc;
  logic                   credit_v;
  vc_id_t                 credit_vc_id;
  logic   [NumInputs-1:0] grant_oh;
  logic                   out_v;
  vc_id_t                 out_vc_id;
  route_dir_e             out_la_route;

  // expected registered result of the vector driven one cycle earlier
  int unsigned exp_grant;
  int unsigned exp_v;
  int unsigned exp_id;
  int unsigned exp_dir;
  bit          have_exp;
  int unsigned errors;

  output_alloc_top #(
    .RouterX (coord_t'(1)),
    .RouterY (coord_t'(1))
  ) u_output_alloc_top (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .req_v_i              (req_v),
    .dest_x_i             (dest_x),
    .dest_y_i             (dest_y),
    .require_correct_vc_i (require_correct_vc),
    .credit_v_i           (credit_v),
    .credit_vc_id_i       (credit_vc_id),
    .grant_oh_o           (grant_oh),
    .out_v_o              (out_v),
    .out_vc_id_o          (out_vc_id),
    .out_la_route_o       (out_la_route)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset covers the first two rising edges
  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // four-state compare so an unknown output never passes
  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      abort_run($sformatf("MISMATCH at %0d ns: %s is %0h, expected %0h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_outputs();
    check_field("grant_oh_o", grant_oh, exp_grant);
    check_field("out_v_o", out_v, exp_v);
    // vc id and direction are don't care on a failed allocation
    if (exp_v != 0) begin
      check_field("out_vc_id_o", out_vc_id, exp_id);
      check_field("out_la_route_o", out_la_route, exp_dir);
    end
  endtask

  task automatic drive_idle();
    req_v              = '0;
    dest_x             = '0;
    dest_y             = '0;
    require_correct_vc = 1'b0;
    credit_v           = 1'b0;
    credit_vc_id       = '0;
  endtask

  // one data line: stimulus for this cycle, expectation for the next
  task automatic apply_vector(input string line);
    int unsigned f[18];
    int          count;
    count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
    if (count != 18) begin
      abort_run({"data line has the wrong number of fields: ", line});
    end else begin
      req_v = f[0][NumInputs-1:0];
      for (int i = 0; i < NumInputs; i++) begin
        dest_x[i] = coord_t'(f[1 + 2 * i]);
        dest_y[i] = coord_t'(f[2 + 2 * i]);
      end
      require_correct_vc = f[11][0];
      credit_v           = f[12][0];
      credit_vc_id       = vc_id_t'(f[13]);
      exp_grant          = f[14];
      exp_v              = f[15];
      exp_id             = f[16];
      exp_dir            = f[17];
    end
  endtask

  initial begin
    int          fd;
    int          code;
    int unsigned wait_cycles;
    int unsigned line_count;
    string       line;
    bit          done;

    errors      = 0;
    have_exp    = 1'b0;
    wait_cycles = 0;
    drive_idle();

    while (arst_n !== 1'b1 && wait_cycles < ResetWaitCycles) begin
      @(negedge clk);
      wait_cycles++;
    end

    if (arst_n !== 1'b1) begin
      abort_run("reset was not released within the expected number of cycles");
    end else begin
      fd = $fopen(DataFile, "r");
      if (fd == 0) begin
        abort_run({"could not open the data file ", DataFile});
      end else begin
        done       = 1'b0;
        line_count = 0;
        while (!done) begin
          code = $fgets(line, fd);
          line_count++;
          if (code == 0) begin
            abort_run("data file ended before its end marker line");
          end else if (line_count > MaxDataLines) begin
            abort_run("data file has no end marker within the line limit");
          end else if (line.substr(0, 2) == "end") begin
            done = 1'b1;
          end else if (line.getc(0) != "#" && line.len() > 1) begin
            // previous result was registered at the last rising edge
            @(negedge clk);
            if (have_exp) begin
              check_outputs();
            end
            apply_vector(line);
            have_exp = 1'b1;
          end
        end
        $fclose(fd);

        @(negedge clk);
        if (have_exp) begin
          check_outputs();
        end
        drive_idle();

        if (errors == 0) begin
          $display("Finished with no errors");
        end else begin
          $display("Finished with errors");
        end
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/output_alloc_testdata.txt ====
# req dx0 dy0 dx1 dy1 dx2 dy2 dx3 dy3 dx4 dy4 rc cv cid  grant v id dir (all hex)
# last four columns are the registered result one cycle later, router at (1,1)
# round robin, look-ahead directions and preferred vcs
00 2 2 3 1 2 0 2 1 6 3 0 0 0  00 0 0 0
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  01 1 0 0
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  02 1 1 1
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  04 1 2 2
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  08 1 3 4
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  10 1 1 1
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  01 1 0 0
# vc 1 empty, strict refusal keeps the pointer on input 1
1f 2 2 3 1 2 0 2 1 6 3 1 0 0  00 0 0 0
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  02 1 2 1
# credit returns refill every vc
00 2 2 3 1 2 0 2 1 6 3 0 1 0  00 0 0 0
00 2 2 3 1 2 0 2 1 6 3 0 1 0  00 0 0 0
00 2 2 3 1 2 0 2 1 6 3 0 1 1  00 0 0 0
00 2 2 3 1 2 0 2 1 6 3 0 1 1  00 0 0 0
00 2 2 3 1 2 0 2 1 6 3 0 1 2  00 0 0 0
00 2 2 3 1 2 0 2 1 6 3 0 1 2  00 0 0 0
00 2 2 3 1 2 0 2 1 6 3 0 1 3  00 0 0 0
# south flits use up vc 2, then strict and fallback
04 2 2 3 1 2 0 2 1 6 3 0 0 0  04 1 2 2
04 2 2 3 1 2 0 2 1 6 3 0 0 0  04 1 2 2
04 2 2 3 1 2 0 2 1 6 3 1 0 0  00 0 0 0
04 2 2 3 1 2 0 2 1 6 3 0 0 0  04 1 0 2
# east flits drain the rest, one return on vc 1 gives one more
02 2 2 3 1 2 0 2 1 6 3 0 0 0  02 1 1 1
02 2 2 3 1 2 0 2 1 6 3 0 0 0  02 1 1 1
02 2 2 3 1 2 0 2 1 6 3 0 0 0  02 1 0 1
02 2 2 3 1 2 0 2 1 6 3 0 0 0  02 1 3 1
02 2 2 3 1 2 0 2 1 6 3 0 0 0  02 1 3 1
1f 2 2 3 1 2 0 2 1 6 3 0 0 0  00 0 0 0
00 2 2 3 1 2 0 2 1 6 3 0 1 1  00 0 0 0
02 2 2 3 1 2 0 2 1 6 3 1 0 0  02 1 1 1
02 2 2 3 1 2 0 2 1 6 3 0 0 0  00 0 0 0
end

// ==== verilog.f ====
design/noc_route_pkg.sv
design/noc_vc_pkg.sv
design/sa_global_arbiter.sv
design/look_ahead_route.sv
design/vc_credit_tracker.sv
design/vc_selection.sv
design/vc_assignment.sv
design/output_alloc_top.sv
sim/tb_output_alloc.sv

// ==== Bender.yml ====
package:
  name: output_alloc

sources:
  - design/noc_route_pkg.sv
  - design/noc_vc_pkg.sv
  - design/sa_global_arbiter.sv
  - design/look_ahead_route.sv
  - design/vc_credit_tracker.sv
  - design/vc_selection.sv
  - design/vc_assignment.sv
  - design/output_alloc_top.sv
  - target: simulation
    files:
      - sim/tb_output_alloc.sv
